// File: rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural register file of RV32I.
`define ARCH_REGS      32
`define ARCH_REG_BITS  5

// physical register file shared by all in-flight results.
`define PHYS_REGS      64
`define PHYS_REG_BITS  6

// registers left free after the identity map is set up.
`define FREE_REGS      (`PHYS_REGS - `ARCH_REGS)
`define FREE_PTR_BITS  5
`define FREE_CNT_BITS  6

`endif

// File: rv32i_types.sv
`default_nettype none
`include "rename_macros.svh"

package rv32i_types;

    typedef logic [`ARCH_REG_BITS-1:0] arch_reg_t;  // architectural register index.
    typedef logic [`PHYS_REG_BITS-1:0] phys_reg_t;  // physical register index.
    typedef logic [31:0]               inst_t;

    // canonical nop, addi x0, x0, 0.
    localparam inst_t NOP_INST = 32'h0000_0013;

    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } opcode_e;

endpackage : rv32i_types

`default_nettype wire

// File: rename_decode.sv
`default_nettype none

module rename_decode import rv32i_types::*; (
    input  inst_t     inst,
    output arch_reg_t rd,
    output arch_reg_t rs1,
    output arch_reg_t rs2,
    output opcode_e   opcode,
    output logic      is_nop,
    output logic      writes_rd,
    output logic      uses_rs2
);

    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign opcode = opcode_e'(inst[6:0]);

    assign is_nop = (inst == NOP_INST) || (inst == '0);

    // branches and stores have no destination, and x0 is never renamed.
    always_comb begin
        case (opcode)
            op_b_br,
            op_b_store: begin
                writes_rd = 1'b0;
            end
            default: begin
                writes_rd = (rd != '0);
            end
        endcase
    end

    always_comb begin
        case (opcode)
            op_b_imm,
            op_b_lui,
            op_b_auipc,
            op_b_jal,
            op_b_jalr,
            op_b_load: begin
                uses_rs2 = 1'b0;  // the rs2 field is immediate bits here.
            end
            default: begin
                uses_rs2 = 1'b1;
            end
        endcase
    end

endmodule : rename_decode

`default_nettype wire

// File: rat.sv
`default_nettype none
`include "rename_macros.svh"

module rat import rv32i_types::*; (
    input  logic      clk,
    input  logic      rst,
    input  arch_reg_t rd_dispatch,
    input  arch_reg_t rs1,
    input  arch_reg_t rs2,
    input  arch_reg_t rd_add,
    input  arch_reg_t rd_mul,
    input  arch_reg_t rd_div,
    input  phys_reg_t pd_dispatch,
    input  phys_reg_t pd_add,
    input  phys_reg_t pd_mul,
    input  phys_reg_t pd_div,
    input  logic      regf_we_dispatch,
    input  logic      regf_we_add,
    input  logic      regf_we_mul,
    input  logic      regf_we_div,
    input  logic      is_nop,
    input  logic      uses_rs2,
    output phys_reg_t ps1,
    output phys_reg_t ps2,
    output phys_reg_t pd_old,
    output logic      ps1_valid,
    output logic      ps2_valid
);

    phys_reg_t map_q   [`ARCH_REGS];
    logic      ready_q [`ARCH_REGS];
    phys_reg_t map_d   [`ARCH_REGS];
    logic      ready_d [`ARCH_REGS];

    // source lookup sees the table as it stood before this edge.
    always_comb begin
        if (is_nop) begin
            ps1       = '0;
            ps2       = '0;
            ps1_valid = 1'b1;
            ps2_valid = 1'b1;
        end else begin
            ps1       = map_q[rs1];
            ps1_valid = ready_q[rs1];
            if (uses_rs2) begin
                ps2       = map_q[rs2];
                ps2_valid = ready_q[rs2];
            end else begin
                ps2       = map_q[rs1];
                ps2_valid = 1'b1;
            end
        end
    end

    assign pd_old = map_q[rd_dispatch];  // freed later when this instruction commits.

    always_comb begin
        map_d   = map_q;
        ready_d = ready_q;
        // a stale broadcast no longer matches the mapping and is ignored.
        if (regf_we_add && (pd_add == map_q[rd_add])) begin
            ready_d[rd_add] = 1'b1;
        end
        if (regf_we_mul && (pd_mul == map_q[rd_mul])) begin
            ready_d[rd_mul] = 1'b1;
        end
        if (regf_we_div && (pd_div == map_q[rd_div])) begin
            ready_d[rd_div] = 1'b1;
        end
        // the remap comes last so a new mapping beats a same-cycle wakeup.
        if (regf_we_dispatch) begin
            map_d[rd_dispatch]   = pd_dispatch;
            ready_d[rd_dispatch] = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i]   <= phys_reg_t'(i);
                ready_q[i] <= 1'b1;
            end
        end else begin
            map_q   <= map_d;
            ready_q <= ready_d;
        end
    end

endmodule : rat

`default_nettype wire

// File: free_list.sv
`default_nettype none
`include "rename_macros.svh"

module free_list import rv32i_types::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc,
    input  logic      release_valid,
    input  phys_reg_t release_pd,
    output phys_reg_t free_pd,
    output logic      empty
);

    phys_reg_t                 fifo_q [`FREE_REGS];
    logic [`FREE_PTR_BITS-1:0] head_q;
    logic [`FREE_PTR_BITS-1:0] tail_q;
    logic [`FREE_CNT_BITS-1:0] count_q;

    assign free_pd = fifo_q[head_q];  // the register the next allocation takes.
    assign empty   = (count_q == '0);

    // the pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (alloc) begin
                head_q <= head_q + 1'b1;
            end
            if (release_valid) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= `FREE_CNT_BITS'(`FREE_REGS);
        end else begin
            case ({alloc, release_valid})
                2'b10: begin
                    count_q <= count_q - 1'b1;
                end
                2'b01: begin
                    count_q <= count_q + 1'b1;
                end
                default: begin
                    count_q <= count_q;  // both or neither leave the count alone.
                end
            endcase
        end
    end

    // every register above the identity map starts out free.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FREE_REGS; i++) begin
                fifo_q[i] <= phys_reg_t'(`PHYS_REGS - `FREE_REGS + i);
            end
        end else if (release_valid) begin
            fifo_q[tail_q] <= release_pd;
        end
    end

endmodule : free_list

`default_nettype wire

// File: rename_stage.sv
`default_nettype none

module rename_stage import rv32i_types::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch,
    input  inst_t     inst,
    input  logic      regf_we_add,
    input  logic      regf_we_mul,
    input  logic      regf_we_div,
    input  arch_reg_t rd_add,
    input  arch_reg_t rd_mul,
    input  arch_reg_t rd_div,
    input  phys_reg_t pd_add,
    input  phys_reg_t pd_mul,
    input  phys_reg_t pd_div,
    input  phys_reg_t release_pd,
    input  logic      release_valid,
    output phys_reg_t ps1,
    output phys_reg_t ps2,
    output phys_reg_t pd,
    output phys_reg_t pd_old,
    output logic      ps1_valid,
    output logic      ps2_valid,
    output logic      stall
);

    arch_reg_t rd;
    arch_reg_t rs1;
    arch_reg_t rs2;
    logic      is_nop;
    logic      writes_rd;
    logic      uses_rs2;
    phys_reg_t free_pd;
    logic      empty;
    logic      rename_we;

    // a stalled instruction touches neither the free list nor the table.
    assign rename_we = dispatch && writes_rd && !empty;
    assign stall     = dispatch && writes_rd && empty;
    assign pd        = free_pd;

    rename_decode u_decode (
        .inst(inst), .rd(rd), .rs1(rs1), .rs2(rs2), .opcode(),
        .is_nop(is_nop), .writes_rd(writes_rd), .uses_rs2(uses_rs2)
    );

    free_list u_free_list (
        .clk(clk), .rst(rst), .alloc(rename_we), .release_valid(release_valid),
        .release_pd(release_pd), .free_pd(free_pd), .empty(empty)
    );

    rat u_rat (
        .clk(clk), .rst(rst), .rd_dispatch(rd), .rs1(rs1), .rs2(rs2),
        .rd_add(rd_add), .rd_mul(rd_mul), .rd_div(rd_div),
        .pd_dispatch(free_pd), .pd_add(pd_add), .pd_mul(pd_mul), .pd_div(pd_div),
        .regf_we_dispatch(rename_we), .regf_we_add(regf_we_add),
        .regf_we_mul(regf_we_mul), .regf_we_div(regf_we_div),
        .is_nop(is_nop), .uses_rs2(uses_rs2), .ps1(ps1), .ps2(ps2), .pd_old(pd_old),
        .ps1_valid(ps1_valid), .ps2_valid(ps2_valid)
    );

endmodule : rename_stage

`default_nettype wire

// File: rename_stage_assert.sv
`default_nettype none
`include "rename_macros.svh"

module rename_stage_assert import rv32i_types::*; (
    input logic      clk,
    input logic      rst,
    input logic      stall,
    input logic      rename_we,
    input logic      release_valid,
    input arch_reg_t rs1,
    input phys_reg_t ps1
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [`FREE_CNT_BITS-1:0] free_cnt;  // occupancy rebuilt from the strobes.

    always_ff @(posedge clk) begin
        if (rst) begin
            free_cnt <= `FREE_CNT_BITS'(`FREE_REGS);
        end else begin
            free_cnt <= free_cnt + `FREE_CNT_BITS'(release_valid) - `FREE_CNT_BITS'(rename_we);
        end
    end

    // a stall only happens once every free register has been handed out.
    no_alloc_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |-> (!rename_we && (free_cnt == '0)))
        else $error("dispatch stalled while the free list still held registers or allocated");

    no_release_when_full: assert property (@(posedge clk) disable iff (rst)
        release_valid |-> (free_cnt != `FREE_CNT_BITS'(`FREE_REGS)))
        else $error("register released into a full free list");

    // x0 is never renamed, so it keeps physical register 0.
    x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1 == '0) |-> (ps1 == '0))
        else $error("source x0 did not read physical register 0");

endmodule : rename_stage_assert

bind rename_stage rename_stage_assert u_assert (
    .clk(clk), .rst(rst), .stall(stall), .rename_we(rename_we),
    .release_valid(release_valid), .rs1(rs1), .ps1(ps1)
);

`default_nettype wire

// File: tb_rename_stage.sv
`default_nettype none
`include "rename_macros.svh"

module tb_rename_stage import rv32i_types::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ROWS  = 512;
    localparam int RAND_ROWS = 300;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    logic      dispatch = 1'b0;
    inst_t     inst = '0;
    logic      regf_we_add = 1'b0, regf_we_mul = 1'b0, regf_we_div = 1'b0;
    arch_reg_t rd_add = '0, rd_mul = '0, rd_div = '0;
    phys_reg_t pd_add = '0, pd_mul = '0, pd_div = '0, release_pd = '0;
    logic      release_valid = 1'b0;
    phys_reg_t ps1, ps2, pd, pd_old;
    logic      ps1_valid, ps2_valid, stall;

    // one row per cycle. a broadcast pd of -1 stands for the mapping of that cycle.
    bit        t_disp [MAX_ROWS];
    inst_t     t_inst [MAX_ROWS];
    bit        t_rel  [MAX_ROWS];
    bit        t_bwe  [MAX_ROWS][3];
    arch_reg_t t_brd  [MAX_ROWS][3];
    int        t_bpd  [MAX_ROWS][3];
    int        n_rows = 0;
    bit        table_ready = 1'b0;

    phys_reg_t m_map [`ARCH_REGS];
    bit        m_rdy [`ARCH_REGS];
    phys_reg_t m_free [$];
    phys_reg_t m_retired [$];  // old mappings whose instructions have committed.

    rename_stage uut (
        .clk(clk), .rst(rst), .dispatch(dispatch), .inst(inst),
        .regf_we_add(regf_we_add), .regf_we_mul(regf_we_mul), .regf_we_div(regf_we_div),
        .rd_add(rd_add), .rd_mul(rd_mul), .rd_div(rd_div),
        .pd_add(pd_add), .pd_mul(pd_mul), .pd_div(pd_div),
        .release_pd(release_pd), .release_valid(release_valid),
        .ps1(ps1), .ps2(ps2), .pd(pd), .pd_old(pd_old),
        .ps1_valid(ps1_valid), .ps2_valid(ps2_valid), .stall(stall)
    );

    always #5 clk = ~clk;

    function automatic inst_t enc(opcode_e op, int rd, int rs1, int rs2);
        return {7'h00, 5'(rs2), 5'(rs1), 3'h0, 5'(rd), op};
    endfunction

    function automatic inst_t random_inst();
        opcode_e ops [9] = '{op_b_lui, op_b_auipc, op_b_jal, op_b_jalr, op_b_br,
                             op_b_load, op_b_store, op_b_imm, op_b_reg};
        inst_t   w;
        w      = $urandom;
        w[6:0] = ops[$urandom_range(8)];
        return w;
    endfunction

    function automatic void classify(input inst_t w, output bit nop, output bit wr,
                                     output bit use2);
        logic [6:0] op;
        op   = w[6:0];
        nop  = (w == 32'h0000_0013) || (w == 32'h0000_0000);
        wr   = (w[11:7] != 5'd0) && !(op inside {op_b_br, op_b_store});
        use2 = !(op inside {op_b_imm, op_b_lui, op_b_auipc, op_b_jal, op_b_jalr, op_b_load});
    endfunction

    task automatic add_row(bit disp, inst_t word, bit rel);
        t_disp[n_rows] = disp;
        t_inst[n_rows] = word;
        t_rel[n_rows]  = rel;
        for (int u = 0; u < 3; u++) begin
            t_bwe[n_rows][u] = 1'b0;
            t_brd[n_rows][u] = '0;
            t_bpd[n_rows][u] = 0;
        end
        n_rows++;
    endtask

    // unit 0 is add, 1 is mul and 2 is div.
    task automatic add_bcast(int u, int rd, int pd_val);
        t_bwe[n_rows-1][u] = 1'b1;
        t_brd[n_rows-1][u] = arch_reg_t'(rd);
        t_bpd[n_rows-1][u] = pd_val;
    endtask

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    initial begin
        wait (table_ready);
        #((n_rows * 20 + 16) * 10);
        $display("run timed out before all %0d rows were applied", n_rows);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        bit        nop, wr, use2, held, e_stall, cur_disp, rel, e_v1, e_v2;
        inst_t     cur_inst;
        phys_reg_t bpd [3];
        phys_reg_t e_ps1, e_ps2, rel_pd;
        int        idx;

        void'($urandom(91));
        for (int i = 0; i < `ARCH_REGS; i++) begin
            m_map[i] = phys_reg_t'(i);
            m_rdy[i] = 1'b1;
            m_free.push_back(phys_reg_t'(i + `ARCH_REGS));
        end
        for (int r = 0; r < `ARCH_REGS; r += 2) begin
            add_row(1'b0, enc(op_b_reg, 0, r, r + 1), 1'b0);
        end
        add_row(1'b1, enc(op_b_reg, 1, 4, 5), 1'b0);
        add_row(1'b1, enc(op_b_reg, 2, 1, 1), 1'b0);
        add_row(1'b1, enc(op_b_reg, 3, 2, 1), 1'b0);
        add_row(1'b1, enc(op_b_reg, 0, 3, 2), 1'b0);  // rd of x0 takes no register.
        add_row(1'b1, enc(op_b_store, 7, 3, 1), 1'b0);
        add_row(1'b1, enc(op_b_reg, 2, 3, 3), 1'b0);
        add_bcast(0, 1, -1);
        add_row(1'b0, enc(op_b_reg, 4, 1, 2), 1'b0);
        add_bcast(1, 2, 33);  // x2 has moved on, so this one is stale.
        add_bcast(2, 3, -1);
        add_row(1'b0, enc(op_b_reg, 4, 2, 3), 1'b0);
        add_row(1'b1, enc(op_b_reg, 1, 1, 1), 1'b0);
        add_bcast(0, 1, -1);
        add_row(1'b0, enc(op_b_reg, 4, 1, 3), 1'b0);
        add_row(1'b1, 32'h0000_0013, 1'b0);
        add_row(1'b0, 32'h0000_0000, 1'b0);
        add_row(1'b0, enc(op_b_imm, 5, 2, 9), 1'b0);
        add_row(1'b0, enc(op_b_lui, 6, 1, 17), 1'b0);
        for (int k = 0; k < `FREE_REGS; k++) begin
            add_row(1'b1, enc(op_b_reg, 1 + k % 31, k, 31 - k), 1'b0);
        end
        add_row(1'b1, enc(op_b_reg, 9, 1, 2), 1'b1);
        add_row(1'b1, enc(op_b_reg, 9, 1, 2), 1'b0);
        add_row(1'b1, enc(op_b_reg, 10, 9, 2), 1'b0);
        for (int k = 0; k < RAND_ROWS; k++) begin
            add_row($urandom_range(2) != 0, random_inst(), $urandom_range(2) != 0);
            for (int u = 0; u < 3; u++) begin
                if ($urandom_range(2) == 0) begin
                    add_bcast(u, int'($urandom_range(31)),
                              ($urandom_range(1) == 0) ? -1 : int'($urandom_range(63)));
                end
            end
        end
        table_ready = 1'b1;

        repeat (16) @(posedge clk);
        rst  <= 1'b0;
        held = 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            if (!held) begin  // a stalled instruction is held until it gets through.
                cur_disp = t_disp[i];
                cur_inst = t_inst[i];
            end
            for (int u = 0; u < 3; u++) begin
                bpd[u] = (t_bpd[i][u] < 0) ? m_map[t_brd[i][u]] : phys_reg_t'(t_bpd[i][u]);
            end
            rel    = t_rel[i] && (m_retired.size() > 0);
            rel_pd = '0;
            if (rel) begin
                idx    = $urandom_range(m_retired.size() - 1);
                rel_pd = m_retired[idx];
                m_retired.delete(idx);
            end
            dispatch      <= cur_disp;
            inst          <= cur_inst;
            regf_we_add   <= t_bwe[i][0];
            regf_we_mul   <= t_bwe[i][1];
            regf_we_div   <= t_bwe[i][2];
            rd_add        <= t_brd[i][0];
            rd_mul        <= t_brd[i][1];
            rd_div        <= t_brd[i][2];
            pd_add        <= bpd[0];
            pd_mul        <= bpd[1];
            pd_div        <= bpd[2];
            release_valid <= rel;
            release_pd    <= rel_pd;

            @(negedge clk);
            classify(cur_inst, nop, wr, use2);
            e_stall = cur_disp && wr && (m_free.size() == 0);
            e_ps1   = nop ? '0 : m_map[cur_inst[19:15]];
            e_v1    = nop ? 1'b1 : m_rdy[cur_inst[19:15]];
            e_ps2   = (nop || use2) ? (nop ? '0 : m_map[cur_inst[24:20]]) : e_ps1;
            e_v2    = (nop || !use2) ? 1'b1 : m_rdy[cur_inst[24:20]];
            check("ps1", 32'(ps1), 32'(e_ps1));
            check("ps2", 32'(ps2), 32'(e_ps2));
            check("ps1_valid", 32'(ps1_valid), 32'(e_v1));
            check("ps2_valid", 32'(ps2_valid), 32'(e_v2));
            check("pd_old", 32'(pd_old), 32'(m_map[cur_inst[11:7]]));
            check("stall", 32'(stall), 32'(e_stall));
            if (cur_disp && wr && !e_stall) begin
                check("pd", 32'(pd), 32'(m_free[0]));
            end

            // the edge ahead wakes first, then a remap of the same rd overrides it.
            for (int u = 0; u < 3; u++) begin
                if (t_bwe[i][u] && (bpd[u] == m_map[t_brd[i][u]])) begin
                    m_rdy[t_brd[i][u]] = 1'b1;
                end
            end
            if (cur_disp && wr && !e_stall) begin
                m_retired.push_back(m_map[cur_inst[11:7]]);
                m_map[cur_inst[11:7]] = m_free.pop_front();
                m_rdy[cur_inst[11:7]] = 1'b0;
            end
            if (rel) begin
                m_free.push_back(rel_pd);
            end
            held = e_stall;
        end
        @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule : tb_rename_stage

`default_nettype wire

// File: rename_stage.f
+incdir+.
rv32i_types.sv
rename_decode.sv
rat.sv
free_list.sv
rename_stage.sv
rename_stage_assert.sv
tb_rename_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the rename stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rename_stage -f rename_stage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_rename_stage 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF "TB PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
